// ==== Makefile ====
# Verilator flow for the write-side slave switch

VERILATOR ?= verilator
TOP       ?= tb_slave_switch_w
FLIST     ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/aw_router.sv ====
/*
 * write address fan-out to three slaves
 * unselected slaves see valid low and zero payload
 * an unmapped address is accepted here, awready follows awvalid
 */
`timescale 1ns/1ns

module aw_router #(
    parameter ADDR_WIDTH = 32,
    parameter ID_WIDTH   = 4
) (
    input  logic                   sys_clk,
    input  logic                   rst,
    // upstream master
    input  logic [ID_WIDTH-1:0]    awid,
    input  logic [ADDR_WIDTH-1:0]  awaddr,
    input  axi_wr_pkg::len_t       awlen,
    input  axi_wr_pkg::size_t      awsize,
    input  axi_wr_pkg::burst_t     awburst,
    input  logic                   awvalid,
    output logic                   awready,
    // slave 0
    output logic [ID_WIDTH-1:0]    s0_awid,
    output logic [ADDR_WIDTH-1:0]  s0_awaddr,
    output axi_wr_pkg::len_t       s0_awlen,
    output axi_wr_pkg::size_t      s0_awsize,
    output axi_wr_pkg::burst_t     s0_awburst,
    output logic                   s0_awvalid,
    input  logic                   s0_awready,
    // slave 1
    output logic [ID_WIDTH-1:0]    s1_awid,
    output logic [ADDR_WIDTH-1:0]  s1_awaddr,
    output axi_wr_pkg::len_t       s1_awlen,
    output axi_wr_pkg::size_t      s1_awsize,
    output axi_wr_pkg::burst_t     s1_awburst,
    output logic                   s1_awvalid,
    input  logic                   s1_awready,
    // slave 2
    output logic [ID_WIDTH-1:0]    s2_awid,
    output logic [ADDR_WIDTH-1:0]  s2_awaddr,
    output axi_wr_pkg::len_t       s2_awlen,
    output axi_wr_pkg::size_t      s2_awsize,
    output axi_wr_pkg::burst_t     s2_awburst,
    output logic                   s2_awvalid,
    input  logic                   s2_awready,
    // controller
    input  axi_wr_pkg::slave_sel_e aw_sel,
    input  logic                   addr_phase,
    output logic                   aw_fire
);

    localparam int AW_W = ID_WIDTH + ADDR_WIDTH + $bits(axi_wr_pkg::len_t)
                        + $bits(axi_wr_pkg::size_t) + $bits(axi_wr_pkg::burst_t) + 1;

    logic [AW_W-1:0] aw_bus;

    assign aw_bus = {awid, awaddr, awlen, awsize, awburst, awvalid};

    // payload and valid go to the selected slave only
    assign {s0_awid, s0_awaddr, s0_awlen, s0_awsize, s0_awburst, s0_awvalid} =
        (addr_phase && aw_sel == axi_wr_pkg::SEL_S0) ? aw_bus : '0;
    assign {s1_awid, s1_awaddr, s1_awlen, s1_awsize, s1_awburst, s1_awvalid} =
        (addr_phase && aw_sel == axi_wr_pkg::SEL_S1) ? aw_bus : '0;
    assign {s2_awid, s2_awaddr, s2_awlen, s2_awsize, s2_awburst, s2_awvalid} =
        (addr_phase && aw_sel == axi_wr_pkg::SEL_S2) ? aw_bus : '0;

    always_comb begin
        awready = 1'b0;
        if (addr_phase) begin
            case (aw_sel)
                axi_wr_pkg::SEL_S0: awready = s0_awready;
                axi_wr_pkg::SEL_S1: awready = s1_awready;
                axi_wr_pkg::SEL_S2: awready = s2_awready;
                // unmapped, take it so the data can be sunk
                default:            awready = awvalid;
            endcase
        end
    end

    assign aw_fire = awvalid && awready;

    aw_valid_onehot: assert property (
        @(posedge sys_clk) disable iff (rst)
        $onehot0({s0_awvalid, s1_awvalid, s2_awvalid})
    );

endmodule

// ==== design/axi_wr_pkg.sv ====
/*
 * shared widths, response codes and enums for the write-side switch
 * slave_sel_e values equal the top two address bits, 00 is unmapped
 */

package axi_wr_pkg;

    // AXI write channel field types
    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;
    typedef logic [1:0] burst_t;
    typedef logic [1:0] resp_t;

    // response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // route, encoded as the address region
    typedef enum logic [1:0] {
        SEL_NONE = 2'b00,
        SEL_S0   = 2'b01,
        SEL_S1   = 2'b10,
        SEL_S2   = 2'b11
    } slave_sel_e;

    // controller phases of one write
    typedef enum logic [1:0] {
        ST_ADDR = 2'b00,
        ST_DATA = 2'b01,
        ST_RESP = 2'b10
    } route_state_e;

endpackage

// ==== design/b_mux.sv ====
/*
 * write response return from the routed slave
 * an unmapped write is answered with DECERR and the latched awid
 */
`timescale 1ns/1ns

module b_mux #(
    parameter ID_WIDTH = 4
) (
    input  logic                   sys_clk,
    input  logic                   rst,
    // upstream master
    output logic [ID_WIDTH-1:0]    bid,
    output axi_wr_pkg::resp_t      bresp,
    output logic                   bvalid,
    input  logic                   bready,
    // slaves
    input  logic [ID_WIDTH-1:0]    s0_bid,
    input  axi_wr_pkg::resp_t      s0_bresp,
    input  logic                   s0_bvalid,
    output logic                   s0_bready,
    input  logic [ID_WIDTH-1:0]    s1_bid,
    input  axi_wr_pkg::resp_t      s1_bresp,
    input  logic                   s1_bvalid,
    output logic                   s1_bready,
    input  logic [ID_WIDTH-1:0]    s2_bid,
    input  axi_wr_pkg::resp_t      s2_bresp,
    input  logic                   s2_bvalid,
    output logic                   s2_bready,
    // controller
    input  axi_wr_pkg::slave_sel_e route,
    input  logic                   resp_phase,
    input  logic [ID_WIDTH-1:0]    awid_q,
    output logic                   b_fire
);

    always_comb begin
        bid       = '0;
        bresp     = axi_wr_pkg::RESP_OKAY;
        bvalid    = 1'b0;
        s0_bready = 1'b0;
        s1_bready = 1'b0;
        s2_bready = 1'b0;
        if (resp_phase) begin
            case (route)
                axi_wr_pkg::SEL_S0: begin
                    bid       = s0_bid;
                    bresp     = s0_bresp;
                    bvalid    = s0_bvalid;
                    s0_bready = bready;
                end
                axi_wr_pkg::SEL_S1: begin
                    bid       = s1_bid;
                    bresp     = s1_bresp;
                    bvalid    = s1_bvalid;
                    s1_bready = bready;
                end
                axi_wr_pkg::SEL_S2: begin
                    bid       = s2_bid;
                    bresp     = s2_bresp;
                    bvalid    = s2_bvalid;
                    s2_bready = bready;
                end
                // unmapped, the switch answers itself
                default: begin
                    bid    = awid_q;
                    bresp  = axi_wr_pkg::RESP_DECERR;
                    bvalid = 1'b1;
                end
            endcase
        end
    end

    assign b_fire = bvalid && bready;

    // controller must leave the response phase right after the handshake
    b_ends_write: assert property (
        @(posedge sys_clk) disable iff (rst)
        b_fire |=> !resp_phase
    );

endmodule

// ==== design/slave_switch_w.sv ====
/*
 * write-side slave switch, one master to three slaves
 * region 01, 10, 11 of the top address bits map to slave 0, 1, 2
 * region 00 is accepted, its data sunk and answered with DECERR
 * one burst in flight, no read channels
 */
`timescale 1ns/1ns

module slave_switch_w #(
    parameter DATA_WIDTH = 32,
    parameter ADDR_WIDTH = 32,
    parameter ID_WIDTH   = 4
) (
    input  logic                    sys_clk,
    input  logic                    rst,
    // ------------------------------
    // upstream master
    // ------------------------------
    input  logic [ID_WIDTH-1:0]     awid,
    input  logic [ADDR_WIDTH-1:0]   awaddr,
    input  axi_wr_pkg::len_t        awlen,
    input  axi_wr_pkg::size_t       awsize,
    input  axi_wr_pkg::burst_t      awburst,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [ID_WIDTH-1:0]     wid,
    input  logic [DATA_WIDTH-1:0]   wdata,
    input  logic [DATA_WIDTH/8-1:0] wstrb,
    input  logic                    wlast,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [ID_WIDTH-1:0]     bid,
    output axi_wr_pkg::resp_t       bresp,
    output logic                    bvalid,
    input  logic                    bready,
    // ------------------------------
    // slave 0
    // ------------------------------
    output logic [ID_WIDTH-1:0]     s0_awid,
    output logic [ADDR_WIDTH-1:0]   s0_awaddr,
    output axi_wr_pkg::len_t        s0_awlen,
    output axi_wr_pkg::size_t       s0_awsize,
    output axi_wr_pkg::burst_t      s0_awburst,
    output logic                    s0_awvalid,
    input  logic                    s0_awready,
    output logic [ID_WIDTH-1:0]     s0_wid,
    output logic [DATA_WIDTH-1:0]   s0_wdata,
    output logic [DATA_WIDTH/8-1:0] s0_wstrb,
    output logic                    s0_wlast,
    output logic                    s0_wvalid,
    input  logic                    s0_wready,
    input  logic [ID_WIDTH-1:0]     s0_bid,
    input  axi_wr_pkg::resp_t       s0_bresp,
    input  logic                    s0_bvalid,
    output logic                    s0_bready,
    // ------------------------------
    // slave 1
    // ------------------------------
    output logic [ID_WIDTH-1:0]     s1_awid,
    output logic [ADDR_WIDTH-1:0]   s1_awaddr,
    output axi_wr_pkg::len_t        s1_awlen,
    output axi_wr_pkg::size_t       s1_awsize,
    output axi_wr_pkg::burst_t      s1_awburst,
    output logic                    s1_awvalid,
    input  logic                    s1_awready,
    output logic [ID_WIDTH-1:0]     s1_wid,
    output logic [DATA_WIDTH-1:0]   s1_wdata,
    output logic [DATA_WIDTH/8-1:0] s1_wstrb,
    output logic                    s1_wlast,
    output logic                    s1_wvalid,
    input  logic                    s1_wready,
    input  logic [ID_WIDTH-1:0]     s1_bid,
    input  axi_wr_pkg::resp_t       s1_bresp,
    input  logic                    s1_bvalid,
    output logic                    s1_bready,
    // ------------------------------
    // slave 2
    // ------------------------------
    output logic [ID_WIDTH-1:0]     s2_awid,
    output logic [ADDR_WIDTH-1:0]   s2_awaddr,
    output axi_wr_pkg::len_t        s2_awlen,
    output axi_wr_pkg::size_t       s2_awsize,
    output axi_wr_pkg::burst_t      s2_awburst,
    output logic                    s2_awvalid,
    input  logic                    s2_awready,
    output logic [ID_WIDTH-1:0]     s2_wid,
    output logic [DATA_WIDTH-1:0]   s2_wdata,
    output logic [DATA_WIDTH/8-1:0] s2_wstrb,
    output logic                    s2_wlast,
    output logic                    s2_wvalid,
    input  logic                    s2_wready,
    input  logic [ID_WIDTH-1:0]     s2_bid,
    input  axi_wr_pkg::resp_t       s2_bresp,
    input  logic                    s2_bvalid,
    output logic                    s2_bready
);

    // controller to router wires
    axi_wr_pkg::slave_sel_e aw_sel;
    axi_wr_pkg::slave_sel_e route;
    logic                   addr_phase;
    logic                   data_phase;
    logic                   resp_phase;
    logic [ID_WIDTH-1:0]    awid_q;
    // handshake completions back to the controller
    logic                   aw_fire;
    logic                   w_last_fire;
    logic                   b_fire;

    // port names match across the tree, so connect by name
    wr_route_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_ctrl (.*);

    aw_router #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_aw (.*);

    w_router #(
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_w (.*);

    b_mux #(
        .ID_WIDTH (ID_WIDTH)
    ) u_b (.*);

endmodule

// ==== design/w_router.sv ====
/*
 * write data fan-out to the routed slave
 * beats of an unmapped write are sunk with wready held high
 * wid is forwarded only, no interleaving is supported
 */
`timescale 1ns/1ns

module w_router #(
    parameter DATA_WIDTH = 32,
    parameter ID_WIDTH   = 4
) (
    input  logic                    sys_clk,
    input  logic                    rst,
    // upstream master
    input  logic [ID_WIDTH-1:0]     wid,
    input  logic [DATA_WIDTH-1:0]   wdata,
    input  logic [DATA_WIDTH/8-1:0] wstrb,
    input  logic                    wlast,
    input  logic                    wvalid,
    output logic                    wready,
    // slave 0
    output logic [ID_WIDTH-1:0]     s0_wid,
    output logic [DATA_WIDTH-1:0]   s0_wdata,
    output logic [DATA_WIDTH/8-1:0] s0_wstrb,
    output logic                    s0_wlast,
    output logic                    s0_wvalid,
    input  logic                    s0_wready,
    // slave 1
    output logic [ID_WIDTH-1:0]     s1_wid,
    output logic [DATA_WIDTH-1:0]   s1_wdata,
    output logic [DATA_WIDTH/8-1:0] s1_wstrb,
    output logic                    s1_wlast,
    output logic                    s1_wvalid,
    input  logic                    s1_wready,
    // slave 2
    output logic [ID_WIDTH-1:0]     s2_wid,
    output logic [DATA_WIDTH-1:0]   s2_wdata,
    output logic [DATA_WIDTH/8-1:0] s2_wstrb,
    output logic                    s2_wlast,
    output logic                    s2_wvalid,
    input  logic                    s2_wready,
    // controller
    input  axi_wr_pkg::slave_sel_e  route,
    input  logic                    data_phase,
    output logic                    w_last_fire
);

    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int W_W        = ID_WIDTH + DATA_WIDTH + STRB_WIDTH + 2;

    logic [W_W-1:0] w_bus;

    assign w_bus = {wid, wdata, wstrb, wlast, wvalid};

    assign {s0_wid, s0_wdata, s0_wstrb, s0_wlast, s0_wvalid} =
        (data_phase && route == axi_wr_pkg::SEL_S0) ? w_bus : '0;
    assign {s1_wid, s1_wdata, s1_wstrb, s1_wlast, s1_wvalid} =
        (data_phase && route == axi_wr_pkg::SEL_S1) ? w_bus : '0;
    assign {s2_wid, s2_wdata, s2_wstrb, s2_wlast, s2_wvalid} =
        (data_phase && route == axi_wr_pkg::SEL_S2) ? w_bus : '0;

    always_comb begin
        wready = 1'b0;
        if (data_phase) begin
            case (route)
                axi_wr_pkg::SEL_S0: wready = s0_wready;
                axi_wr_pkg::SEL_S1: wready = s1_wready;
                axi_wr_pkg::SEL_S2: wready = s2_wready;
                default:            wready = 1'b1;
            endcase
        end
    end

    // end of burst hands over to the response phase
    assign w_last_fire = wvalid && wready && wlast;

    w_valid_in_data: assert property (
        @(posedge sys_clk) disable iff (rst)
        !data_phase |-> !(s0_wvalid || s1_wvalid || s2_wvalid)
    );

endmodule

// ==== design/wr_route_ctrl.sv ====
/*
 * routing controller, one write burst in flight at a time
 * a new address is held off until the previous B handshake
 * the route and awid are latched on the AW handshake
 */
`timescale 1ns/1ns

module wr_route_ctrl #(
    parameter ADDR_WIDTH = 32,
    parameter ID_WIDTH   = 4
) (
    input  logic                   sys_clk,
    input  logic                   rst,
    input  logic [ADDR_WIDTH-1:0]  awaddr,
    input  logic [ID_WIDTH-1:0]    awid,
    input  logic                   aw_fire,
    input  logic                   w_last_fire,
    input  logic                   b_fire,
    output axi_wr_pkg::slave_sel_e aw_sel,
    output logic                   addr_phase,
    output axi_wr_pkg::slave_sel_e route,
    output logic [ID_WIDTH-1:0]    awid_q,
    output logic                   data_phase,
    output logic                   resp_phase
);

    axi_wr_pkg::route_state_e state;
    axi_wr_pkg::route_state_e state_nxt;

    assign addr_phase = (state == axi_wr_pkg::ST_ADDR);
    assign data_phase = (state == axi_wr_pkg::ST_DATA);
    assign resp_phase = (state == axi_wr_pkg::ST_RESP);

    // region decode, only offered to the AW router while idle
    assign aw_sel = addr_phase ? axi_wr_pkg::slave_sel_e'(awaddr[ADDR_WIDTH-1 -: 2])
                               : axi_wr_pkg::SEL_NONE;

    // ------------------------------
    // phase sequencing
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            axi_wr_pkg::ST_ADDR: begin
                if (aw_fire) begin
                    state_nxt = axi_wr_pkg::ST_DATA;
                end
            end
            axi_wr_pkg::ST_DATA: begin
                if (w_last_fire) begin
                    state_nxt = axi_wr_pkg::ST_RESP;
                end
            end
            axi_wr_pkg::ST_RESP: begin
                if (b_fire) begin
                    state_nxt = axi_wr_pkg::ST_ADDR;
                end
            end
            default: begin
                state_nxt = axi_wr_pkg::ST_ADDR;
            end
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state <= axi_wr_pkg::ST_ADDR;
            route <= axi_wr_pkg::SEL_NONE;
        end else begin
            state <= state_nxt;
            if (aw_fire) begin
                route <= aw_sel;
            end
        end
    end

    // id for the decode-error answer
    always_ff @(posedge sys_clk) begin
        if (aw_fire) begin
            awid_q <= awid;
        end
    end

    // the AW router must only complete a handshake while idle
    aw_only_in_addr: assert property (
        @(posedge sys_clk) disable iff (rst)
        aw_fire |-> state == axi_wr_pkg::ST_ADDR
    );

endmodule

// ==== files.f ====
design/axi_wr_pkg.sv
design/wr_route_ctrl.sv
design/aw_router.sv
design/w_router.sv
design/b_mux.sv
design/slave_switch_w.sv
verification/tb_clock_gen.sv
verification/tb_slave_switch_w.sv

// ==== verification/tb_clock_gen.sv ====
/*
 * testbench clock and reset, 100 ns period
 * rst is high for the first 3 cycles and drops on a falling edge
 */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic sys_clk,
    output logic rst
);

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        rst = 1'b0;
    end

endmodule

// ==== verification/tb_slave_switch_w.sv ====
/*
 * testbench for the write-side switch with three random-ready slave models
 * inputs change on the falling edge, outputs are sampled 45 ns later
 * assumes DATA_WIDTH 32, ADDR_WIDTH 32 and ID_WIDTH 4
 */
`timescale 1ns/1ns

module tb_slave_switch_w;

    localparam int TMO = 200;

    logic sys_clk, rst;
    logic [3:0] awid, wid, bid;
    logic [31:0] awaddr, wdata;
    axi_wr_pkg::len_t awlen;
    axi_wr_pkg::size_t awsize;
    axi_wr_pkg::burst_t awburst;
    logic [3:0] wstrb;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    axi_wr_pkg::resp_t bresp;
    // slave side, index n is slave n
    logic [3:0] s_awid [3], s_wid [3], s_bid [3], s_wstrb [3], rec_id [3];
    logic [31:0] s_awaddr [3], s_wdata [3];
    axi_wr_pkg::len_t s_awlen [3];
    axi_wr_pkg::size_t s_awsize [3];
    axi_wr_pkg::burst_t s_awburst [3];
    axi_wr_pkg::resp_t s_bresp [3];
    logic s_awvalid [3], s_awready [3], s_wlast [3], s_wvalid [3], s_wready [3];
    logic s_bvalid [3], s_bready [3], pend_b [3];
    logic s_aw_hs [3], s_wl_hs [3], s_b_hs [3];
    logic up_aw_hs, up_w_hs, up_b_hs;
    // monitor state for the write in flight
    logic busy, timed_out;
    logic [31:0] lat_addr;
    logic [3:0] lat_id;
    int lat_len, lat_idx, beats, errors, writes_done;

    tb_clock_gen clk_gen (.sys_clk(sys_clk), .rst(rst));

    slave_switch_w #(.DATA_WIDTH(32), .ADDR_WIDTH(32), .ID_WIDTH(4)) uut (
        .sys_clk(sys_clk), .rst(rst),
        .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
        .awvalid(awvalid), .awready(awready),
        .wid(wid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid),
        .wready(wready), .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .s0_awid(s_awid[0]), .s0_awaddr(s_awaddr[0]), .s0_awlen(s_awlen[0]),
        .s0_awsize(s_awsize[0]), .s0_awburst(s_awburst[0]), .s0_awvalid(s_awvalid[0]),
        .s0_awready(s_awready[0]), .s0_wid(s_wid[0]), .s0_wdata(s_wdata[0]),
        .s0_wstrb(s_wstrb[0]), .s0_wlast(s_wlast[0]), .s0_wvalid(s_wvalid[0]),
        .s0_wready(s_wready[0]), .s0_bid(s_bid[0]), .s0_bresp(s_bresp[0]),
        .s0_bvalid(s_bvalid[0]), .s0_bready(s_bready[0]),
        .s1_awid(s_awid[1]), .s1_awaddr(s_awaddr[1]), .s1_awlen(s_awlen[1]),
        .s1_awsize(s_awsize[1]), .s1_awburst(s_awburst[1]), .s1_awvalid(s_awvalid[1]),
        .s1_awready(s_awready[1]), .s1_wid(s_wid[1]), .s1_wdata(s_wdata[1]),
        .s1_wstrb(s_wstrb[1]), .s1_wlast(s_wlast[1]), .s1_wvalid(s_wvalid[1]),
        .s1_wready(s_wready[1]), .s1_bid(s_bid[1]), .s1_bresp(s_bresp[1]),
        .s1_bvalid(s_bvalid[1]), .s1_bready(s_bready[1]),
        .s2_awid(s_awid[2]), .s2_awaddr(s_awaddr[2]), .s2_awlen(s_awlen[2]),
        .s2_awsize(s_awsize[2]), .s2_awburst(s_awburst[2]), .s2_awvalid(s_awvalid[2]),
        .s2_awready(s_awready[2]), .s2_wid(s_wid[2]), .s2_wdata(s_wdata[2]),
        .s2_wstrb(s_wstrb[2]), .s2_wlast(s_wlast[2]), .s2_wvalid(s_wvalid[2]),
        .s2_wready(s_wready[2]), .s2_bid(s_bid[2]), .s2_bresp(s_bresp[2]),
        .s2_bvalid(s_bvalid[2]), .s2_bready(s_bready[2])
    );

    // address region table, 00 answers DECERR, others pass the slave's bresp
    function automatic void expected_route(input logic [31:0] addr,
                                           input axi_wr_pkg::resp_t slave_resp,
                                           output axi_wr_pkg::slave_sel_e sel,
                                           output axi_wr_pkg::resp_t resp);
        resp = slave_resp;
        case (addr[31:30])
            2'b01: sel = axi_wr_pkg::SEL_S0;
            2'b10: sel = axi_wr_pkg::SEL_S1;
            2'b11: sel = axi_wr_pkg::SEL_S2;
            default: begin
                sel  = axi_wr_pkg::SEL_NONE;
                resp = axi_wr_pkg::RESP_DECERR;
            end
        endcase
    endfunction

    task automatic check_sel(input axi_wr_pkg::slave_sel_e got,
                             input axi_wr_pkg::slave_sel_e exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_resp(input axi_wr_pkg::resp_t got, input axi_wr_pkg::resp_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout at %0t while waiting for the %s", $time, what);
    endtask

    // ------------------------------
    // comparing process
    // ------------------------------
    task automatic check_cycle();
        axi_wr_pkg::slave_sel_e obs;
        axi_wr_pkg::slave_sel_e exp_sel;
        axi_wr_pkg::resp_t exp_resp;
        axi_wr_pkg::resp_t rec;
        for (int i = 0; i < 3; i++) begin
            if (int'(awaddr[31:30]) != i + 1) begin
                check_data({s_awid[i], s_awlen[i], s_awsize[i], s_awburst[i], s_awvalid[i]},
                           0, $sformatf("unselected slave %0d AW", i));
                check_data(s_awaddr[i], 0, $sformatf("unselected slave %0d awaddr", i));
            end else if (s_awvalid[i]) begin
                check_data(s_awaddr[i], awaddr, "slave awaddr");
                check_data({s_awid[i], s_awlen[i], s_awsize[i], s_awburst[i]},
                           {awid, awlen, awsize, awburst}, "slave awid/len/size/burst");
            end
            if (s_aw_hs[i]) rec_id[i] = s_awid[i];
            if (s_wvalid[i] && (!busy || lat_idx != i)) begin
                errors++;
                $display("slave %0d saw wvalid at %0t without being routed", i, $time);
            end
            if (s_bready[i] && (!busy || lat_idx != i)) begin
                errors++;
                $display("slave %0d saw bready at %0t without being routed", i, $time);
            end
        end
        if (up_aw_hs) begin
            if (busy) begin
                errors++;
                $display("address accepted at %0t before the previous response", $time);
            end
            obs = s_awvalid[0] ? axi_wr_pkg::SEL_S0 : s_awvalid[1] ? axi_wr_pkg::SEL_S1 :
                  s_awvalid[2] ? axi_wr_pkg::SEL_S2 : axi_wr_pkg::SEL_NONE;
            expected_route(awaddr, axi_wr_pkg::RESP_OKAY, exp_sel, exp_resp);
            check_sel(obs, exp_sel, "AW route");
            busy = 1'b1;
            lat_addr = awaddr;
            lat_id = awid;
            lat_len = int'(awlen);
            lat_idx = int'(exp_sel) - 1;
            beats = 0;
        end
        if (up_w_hs) begin
            beats++;
            if (lat_idx >= 0) begin
                check_data({s_wvalid[lat_idx], s_wready[lat_idx]}, 3, "routed W handshake");
                check_data(s_wdata[lat_idx], wdata, "slave wdata");
                check_data({s_wid[lat_idx], s_wstrb[lat_idx], s_wlast[lat_idx]},
                           {wid, wstrb, wlast}, "slave wid/wstrb/wlast");
            end
            if (wlast) check_data(beats, lat_len + 1, "beat count");
        end
        if (up_b_hs) begin
            if (lat_idx >= 0) begin
                check_data({s_bvalid[lat_idx], s_bready[lat_idx]}, 3, "routed B handshake");
            end
            rec = (lat_idx >= 0) ? s_bresp[lat_idx] : axi_wr_pkg::RESP_OKAY;
            expected_route(lat_addr, rec, exp_sel, exp_resp);
            check_resp(bresp, exp_resp, "bresp");
            check_data(bid, lat_id, "bid");
            busy = 1'b0;
            writes_done++;
        end
    endtask

    always begin
        @(negedge sys_clk);
        #45;
        up_aw_hs = awvalid && awready;
        up_w_hs  = wvalid && wready;
        up_b_hs  = bvalid && bready;
        for (int i = 0; i < 3; i++) begin
            s_aw_hs[i] = s_awvalid[i] && s_awready[i];
            s_wl_hs[i] = s_wvalid[i] && s_wready[i] && s_wlast[i];
            s_b_hs[i]  = s_bvalid[i] && s_bready[i];
        end
        if (!rst) check_cycle();
    end

    // slave models, answer with the received awid and a random bresp
    always @(negedge sys_clk) begin : slave_models
        logic [31:0] rv;
        for (int i = 0; i < 3; i++) begin
            if (rst) begin
                s_bvalid[i] = 1'b0;
                pend_b[i] = 1'b0;
            end else begin
                if (s_b_hs[i]) s_bvalid[i] = 1'b0;
                if (s_wl_hs[i]) pend_b[i] = 1'b1;
                if (pend_b[i] && !s_bvalid[i]) begin
                    rv = $urandom;
                    s_bvalid[i] = 1'b1;
                    s_bid[i] = rec_id[i];
                    s_bresp[i] = rv[1:0];
                    pend_b[i] = 1'b0;
                end
            end
            rv = $urandom;
            s_awready[i] = rv[0];
            s_wready[i] = rv[1];
        end
    end

    // ------------------------------
    // upstream master
    // ------------------------------
    task automatic drive_aw(input logic [31:0] addr, input logic [3:0] id, input int len);
        logic [31:0] rv;
        rv = $urandom;
        awaddr = addr;
        awid = id;
        awlen = len[7:0];
        awsize = 3'd2;
        awburst = rv[1:0];
        awvalid = 1'b1;
    endtask

    // called on a falling edge, returns on the falling edge after the B handshake
    task automatic write_burst(input logic [31:0] addr, input logic [3:0] id, input int len,
                               input bit early, input logic [31:0] nxt_addr,
                               input logic [3:0] nxt_id, input int nxt_len);
        logic [31:0] rv;
        int n;
        if (timed_out) return;
        if (!awvalid) drive_aw(addr, id, len);
        for (n = 0; n < TMO; n++) begin
            @(negedge sys_clk);
            if (up_aw_hs) break;
        end
        awvalid = 1'b0;
        if (n == TMO) begin
            timeout("address handshake");
            return;
        end
        for (int b = 0; b <= len; b++) begin
            rv = $urandom;
            wdata = rv;
            rv = $urandom;
            wstrb = rv[3:0];
            wid = id;
            wlast = (b == len);
            wvalid = 1'b1;
            for (n = 0; n < TMO; n++) begin
                @(negedge sys_clk);
                if (up_w_hs) break;
            end
            if (n == TMO) begin
                timeout("data handshake");
                return;
            end
        end
        wvalid = 1'b0;
        wlast = 1'b0;
        // next address waits upstream while this write finishes
        if (early) drive_aw(nxt_addr, nxt_id, nxt_len);
        for (n = 0; n < TMO; n++) begin
            rv = $urandom;
            bready = rv[0];
            @(negedge sys_clk);
            if (up_b_hs) break;
        end
        bready = 1'b0;
        if (n == TMO) timeout("response handshake");
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %-16s %s", name, (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin : stimulus
        logic [31:0] rv;
        logic [31:0] addrs [6];
        int e0;
        int n;
        void'($urandom(32'h2b17));
        {awid, awaddr, awlen, awsize, awburst, awvalid} = '0;
        {wid, wdata, wstrb, wlast, wvalid, bready} = '0;
        for (int i = 0; i < 3; i++) begin
            {s_bid[i], s_bresp[i], s_bvalid[i], s_awready[i], s_wready[i]} = '0;
            {pend_b[i], rec_id[i], s_aw_hs[i], s_wl_hs[i], s_b_hs[i]} = '0;
        end
        {up_aw_hs, up_w_hs, up_b_hs, busy, timed_out} = '0;
        lat_addr = '0;
        lat_id = '0;
        {lat_len, lat_idx, beats, errors, writes_done} = '0;
        for (n = 0; n < TMO; n++) begin
            @(posedge sys_clk);
            if (!rst) break;
        end
        if (n == TMO) timeout("reset release");
        @(negedge sys_clk);

        e0 = errors;
        for (int r = 1; r < 4; r++) begin
            rv = $urandom;
            write_burst({r[1:0], rv[29:0]}, rv[3:0], 0, 0, 0, 0, 0);
        end
        report_test("address decode", e0);

        e0 = errors;
        for (int r = 1; r < 4; r++) begin
            rv = $urandom;
            write_burst({r[1:0], rv[29:0]}, rv[7:4], int'(rv[2:0]) + 1, 0, 0, 0, 0);
        end
        report_test("data routing", e0);

        e0 = errors;
        for (int k = 0; k < 6; k++) begin
            rv = $urandom;
            write_burst({2'(k % 3 + 1), rv[29:0]}, rv[11:8], int'(rv[1:0]), 0, 0, 0, 0);
        end
        report_test("response return", e0);

        e0 = errors;
        rv = $urandom;
        write_burst({2'b00, rv[29:0]}, 4'h9, 3, 0, 0, 0, 0);
        report_test("unmapped write", e0);

        e0 = errors;
        for (int k = 0; k < 6; k++) begin
            rv = $urandom;
            addrs[k] = rv;
        end
        for (int k = 0; k < 6; k++) begin
            write_burst(addrs[k], 4'(k), k % 4, k < 5, addrs[(k + 1) % 6], 4'(k + 1),
                        (k + 1) % 4);
        end
        report_test("back-pressure", e0);

        $display("writes %0d, errors %0d", writes_done, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
